//--- rtl/freq_pkg.sv
/*
   Frequency monitor shared definitions
   Belt, comb, CORDIC and measurement window widths, channel identifiers
*/
package freq_pkg;

   // Conveyor belt, I/Q of field, forward, reverse, fiber, drive, spare
   localparam int n_chan     = 12;
   localparam int sr_wi      = 40;

   // Comb stage
   localparam int comb_outw  = 20;
   localparam int shift_base = 4;

   // CORDIC input sample, top bits of the comb result
   localparam int samp_w     = 18;
   // Phase, full turn is 2**phase_w
   localparam int phase_w    = 17;
   // Magnitude keeps the CORDIC gain of about 1.647
   localparam int mag_w      = 17;
   localparam int cordic_iters = 16;
   // Internal datapath, two guard bits on top and two fraction bits below
   localparam int cordic_w   = samp_w + 4;
   // Internal angle carries two extra LSBs for table accuracy
   localparam int angle_w    = phase_w + 2;

   // Measurement window of 2**window_log pairs
   localparam int window_log = 6;
   localparam int refcnt_w   = phase_w;
   localparam int acc_w      = phase_w + window_log;

   // channel_sel values
   localparam logic [1:0] field_chid = 2'd0;
   localparam logic [1:0] fwd_chid   = 2'd1;
   localparam logic [1:0] rev_chid   = 2'd2;
   localparam logic [1:0] iqfib_chid = 2'd3;

endpackage

//--- rtl/cic_comb_shift.sv
/*
   CIC comb stage for the conveyor belt
   Subtracts the word one frame back, shifts left and saturates
*/
module cic_comb_shift (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [freq_pkg::sr_wi-1:0]            sr_in,
   input  logic                                  sr_valid,
   input  logic [3:0]                            shift,
   output logic signed [freq_pkg::comb_outw-1:0] result,
   output logic                                  strobe
);

   // Delay line, one slot per belt word
   logic [freq_pkg::sr_wi-1:0] dline [freq_pkg::n_chan];
   logic signed [freq_pkg::sr_wi-1:0] diff;
   logic valid_d;

   // Room for the largest shift of shift_base plus 15
   logic signed [freq_pkg::sr_wi+freq_pkg::shift_base+14:0] wide;
   logic [4:0] shl;
   logic signed [freq_pkg::comb_outw-1:0] sat_val;

   // Delay line advances only on valid words
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < freq_pkg::n_chan; k++) begin
            dline[k] <= '0;
         end
         valid_d <= 1'b0;
         strobe  <= 1'b0;
      end else begin
         valid_d <= sr_valid;
         strobe  <= valid_d;
         if (sr_valid) begin
            dline[0] <= sr_in;
            for (int k = 1; k < freq_pkg::n_chan; k++) begin
               dline[k] <= dline[k-1];
            end
         end
      end
   end

   // Difference wraps modulo 2**sr_wi, matching the upstream integrator
   always_ff @(posedge clk) begin
      if (sr_valid) begin
         diff <= sr_in - dline[freq_pkg::n_chan-1];
      end
      if (valid_d) begin
         result <= sat_val;
      end
   end

   // Shift and clamp to comb_outw bits
   always_comb begin
      shl  = 5'(freq_pkg::shift_base) + 5'(shift);
      wide = diff;
      wide = wide <<< shl;
      if (&wide[$high(wide):freq_pkg::comb_outw-1] ||
          ~|wide[$high(wide):freq_pkg::comb_outw-1]) begin
         sat_val = wide[freq_pkg::comb_outw-1:0];
      end else if (wide[$high(wide)]) begin
         // Negative overflow
         sat_val = {1'b1, {(freq_pkg::comb_outw-1){1'b0}}};
      end else begin
         sat_val = {1'b0, {(freq_pkg::comb_outw-1){1'b1}}};
      end
   end

endmodule

//--- rtl/chan_subset.sv
/*
   Belt channel subset
   Keeps the words whose frame position is set in the mask
   and flags a frame that runs into the next one
*/
module chan_subset (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic signed [freq_pkg::comb_outw-1:0] data_in,
   input  logic                                  gate_in,
   input  logic [freq_pkg::n_chan-1:0]           keep,
   output logic signed [freq_pkg::samp_w-1:0]    data_out,
   output logic                                  gate_out,
   output logic                                  time_err
);

   // Next expected position and the position of the current word
   logic [$clog2(freq_pkg::n_chan)-1:0] cnt;
   logic [$clog2(freq_pkg::n_chan)-1:0] pos;
   logic gate_d;

   // First word after a gap is position zero
   assign pos = gate_d ? cnt : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt      <= '0;
         gate_d   <= 1'b0;
         gate_out <= 1'b0;
         time_err <= 1'b0;
      end else begin
         gate_d   <= gate_in;
         gate_out <= gate_in & keep[pos];
         // cnt only returns to zero mid-gate after a full frame,
         // so a word here means the frames overlap
         time_err <= gate_in & gate_d & (cnt == '0);
         if (gate_in) begin
            if (pos == freq_pkg::n_chan - 1) begin
               cnt <= '0;
            end else begin
               cnt <= pos + 1'b1;
            end
         end
      end
   end

   // Top samp_w bits of the comb word
   always_ff @(posedge clk) begin
      if (gate_in) begin
         data_out <= data_in[freq_pkg::comb_outw-1 -: freq_pkg::samp_w];
      end
   end

endmodule

//--- rtl/iq_phase_track.sv
/*
   Iterative vectoring CORDIC
   Takes I then Q, reports phase and gain-scaled magnitude,
   drops a pair that arrives while busy
*/
module iq_phase_track (
   input  logic                               clk,
   input  logic                               reset,
   input  logic signed [freq_pkg::samp_w-1:0] sample,
   input  logic                               sample_gate,
   output logic [freq_pkg::phase_w-1:0]       phase,
   output logic [freq_pkg::mag_w-1:0]         magnitude,
   output logic                               pair_strobe,
   output logic                               overrun_err
);

   logic signed [freq_pkg::samp_w-1:0] i_hold;
   logic have_i;
   logic skip_q;
   logic busy;
   logic take_i;
   logic load_q;
   logic [$clog2(freq_pkg::cordic_iters)-1:0] step;

   logic signed [freq_pkg::cordic_w-1:0] i_ext, q_ext;
   logic signed [freq_pkg::cordic_w-1:0] xr, yr;
   logic signed [freq_pkg::cordic_w-1:0] x_div, y_div;
   logic [freq_pkg::angle_w-1:0] zr, z_rnd;

   // atan(2**-idx) with 2**angle_w per turn
   function automatic logic [freq_pkg::angle_w-1:0] atan_lut(input logic [3:0] idx);
      case (idx)
         4'd0:    atan_lut = 19'd65536;
         4'd1:    atan_lut = 19'd38688;
         4'd2:    atan_lut = 19'd20442;
         4'd3:    atan_lut = 19'd10377;
         4'd4:    atan_lut = 19'd5208;
         4'd5:    atan_lut = 19'd2607;
         4'd6:    atan_lut = 19'd1304;
         4'd7:    atan_lut = 19'd652;
         4'd8:    atan_lut = 19'd326;
         4'd9:    atan_lut = 19'd163;
         4'd10:   atan_lut = 19'd81;
         4'd11:   atan_lut = 19'd41;
         4'd12:   atan_lut = 19'd20;
         4'd13:   atan_lut = 19'd10;
         4'd14:   atan_lut = 19'd5;
         default: atan_lut = 19'd3;
      endcase
   endfunction

   // I is accepted only when idle, Q always pairs with a held I
   assign take_i = sample_gate & ~have_i & ~skip_q & ~busy;
   assign load_q = sample_gate & have_i;

   // Sign extend and append the fraction bits
   assign i_ext = $signed({i_hold, 2'b00});
   assign q_ext = $signed({sample, 2'b00});

   assign x_div = xr >>> step;
   assign y_div = yr >>> step;

   always_ff @(posedge clk) begin
      if (reset) begin
         have_i      <= 1'b0;
         skip_q      <= 1'b0;
         busy        <= 1'b0;
         step        <= '0;
         pair_strobe <= 1'b0;
         overrun_err <= 1'b0;
      end else begin
         pair_strobe <= 1'b0;
         overrun_err <= 1'b0;
         if (load_q) begin
            have_i <= 1'b0;
            busy   <= 1'b1;
            step   <= '0;
         end else if (sample_gate && skip_q) begin
            // Q of a dropped pair
            skip_q <= 1'b0;
         end else if (sample_gate && busy) begin
            overrun_err <= 1'b1;
            skip_q      <= 1'b1;
         end else if (take_i) begin
            have_i <= 1'b1;
         end
         if (busy) begin
            step <= step + 1'b1;
            if (step == freq_pkg::cordic_iters - 1) begin
               busy        <= 1'b0;
               pair_strobe <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_i) begin
         i_hold <= sample;
      end
      if (load_q) begin
         // Left half plane, rotate by half a turn first
         if (i_ext[freq_pkg::cordic_w-1]) begin
            xr <= -i_ext;
            yr <= -q_ext;
            zr <= {1'b1, {(freq_pkg::angle_w-1){1'b0}}};
         end else begin
            xr <= i_ext;
            yr <= q_ext;
            zr <= '0;
         end
      end else if (busy) begin
         // Drive y towards zero, z collects the angle
         if (!yr[freq_pkg::cordic_w-1]) begin
            xr <= xr + y_div;
            yr <= yr - x_div;
            zr <= zr + atan_lut(step);
         end else begin
            xr <= xr - y_div;
            yr <= yr + x_div;
            zr <= zr - atan_lut(step);
         end
      end
   end

   // Round off the two extra angle bits
   assign z_rnd = zr + freq_pkg::angle_w'(2);
   assign phase = z_rnd[freq_pkg::angle_w-1:2];

   // x stays non-negative, clamp to mag_w bits
   always_comb begin
      if (|xr[freq_pkg::cordic_w-1:freq_pkg::mag_w+2]) begin
         magnitude = '1;
      end else begin
         magnitude = xr[freq_pkg::mag_w+1:2];
      end
   end

endmodule

//--- rtl/freq_accum.sv
/*
   Frequency and amplitude accumulator
   Averages the wrapped phase step over a window of pairs
   and keeps the magnitude extremes
*/
module freq_accum (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [freq_pkg::phase_w-1:0]         phase,
   input  logic [freq_pkg::mag_w-1:0]           magnitude,
   input  logic                                 pair_strobe,
   input  logic                                 overrun,
   output logic signed [freq_pkg::refcnt_w-1:0] freq,
   output logic                                 freq_valid,
   output logic [freq_pkg::mag_w-1:0]           amp_max,
   output logic [freq_pkg::mag_w-1:0]           amp_min,
   output logic                                 updated,
   output logic                                 window_err
);

   logic [freq_pkg::phase_w-1:0] prev_phase;
   logic have_ref;
   logic ovr_seen;
   logic win_close;
   logic [freq_pkg::window_log-1:0] pair_cnt;
   logic signed [freq_pkg::phase_w-1:0] dphase;
   logic signed [freq_pkg::acc_w-1:0] acc, acc_next;
   logic [freq_pkg::mag_w-1:0] run_max, run_min;
   logic [freq_pkg::mag_w-1:0] hi_next, lo_next;

   // Modulo subtraction gives the step within half a turn
   assign dphase   = phase - prev_phase;
   assign acc_next = acc + dphase;

   assign hi_next = (magnitude > run_max) ? magnitude : run_max;
   assign lo_next = (magnitude < run_min) ? magnitude : run_min;

   // Last pair of the window
   assign win_close = pair_strobe & have_ref & (&pair_cnt);

   always_ff @(posedge clk) begin
      if (reset) begin
         have_ref   <= 1'b0;
         ovr_seen   <= 1'b0;
         pair_cnt   <= '0;
         acc        <= '0;
         run_max    <= '0;
         run_min    <= '1;
         freq_valid <= 1'b0;
         updated    <= 1'b0;
         window_err <= 1'b0;
      end else begin
         updated    <= 1'b0;
         window_err <= 1'b0;
         if (overrun) begin
            ovr_seen <= 1'b1;
         end
         if (pair_strobe) begin
            // First pair only sets the reference
            have_ref <= 1'b1;
            if (have_ref) begin
               pair_cnt <= pair_cnt + 1'b1;
               if (win_close) begin
                  freq_valid <= ~(ovr_seen | overrun);
                  window_err <= ovr_seen | overrun;
                  updated    <= 1'b1;
                  acc        <= '0;
                  run_max    <= '0;
                  run_min    <= '1;
                  ovr_seen   <= 1'b0;
               end else begin
                  acc     <= acc_next;
                  run_max <= hi_next;
                  run_min <= lo_next;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pair_strobe) begin
         prev_phase <= phase;
      end
      if (win_close) begin
         // Sum over 2**window_log steps, so drop window_log bits
         freq    <= acc_next[freq_pkg::acc_w-1:freq_pkg::window_log];
         amp_max <= hi_next;
         amp_min <= lo_next;
      end
   end

endmodule

//--- rtl/freq_monitor_top.sv
/*
   Cavity frequency monitor
   Comb, channel pick, CORDIC and window average on the CIC belt
*/
module freq_monitor_top (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [1:0]                           channel_sel,
   input  logic                                 sample_wave,
   input  logic [3:0]                           wave_shift,
   input  logic                                 sr_valid,
   input  logic [freq_pkg::sr_wi-1:0]           sr_data,
   output logic signed [freq_pkg::refcnt_w-1:0] reg_freq,
   output logic                                 reg_freq_valid,
   output logic [freq_pkg::mag_w-1:0]           reg_amp_max,
   output logic [freq_pkg::mag_w-1:0]           reg_amp_min,
   output logic                                 reg_updated,
   output logic                                 reg_timing_err
);

   logic sample_valid;
   logic signed [freq_pkg::comb_outw-1:0] comb_result;
   logic comb_strobe;
   logic [freq_pkg::n_chan-1:0] chan_mask;
   logic [freq_pkg::n_chan-1:0] keep_mask;
   logic signed [freq_pkg::samp_w-1:0] sub_data;
   logic sub_gate;
   logic [freq_pkg::phase_w-1:0] phase;
   logic [freq_pkg::mag_w-1:0] magnitude;
   logic pair_strobe;
   logic subset_err, overrun_err, window_err;

   // Belt sampling enable
   assign sample_valid = sr_valid & sample_wave;

   cic_comb_shift comb (
      .clk      (clk),
      .reset    (reset),
      .sr_in    (sr_data),
      .sr_valid (sample_valid),
      .shift    (wave_shift),
      .result   (comb_result),
      .strobe   (comb_strobe)
   );

   // I and Q of the selected signal sit in adjacent belt slots
   always_comb begin
      chan_mask = '0;
      case (channel_sel)
         freq_pkg::field_chid: chan_mask[1:0] = 2'b11;
         freq_pkg::fwd_chid:   chan_mask[3:2] = 2'b11;
         freq_pkg::rev_chid:   chan_mask[5:4] = 2'b11;
         freq_pkg::iqfib_chid: chan_mask[7:6] = 2'b11;
      endcase
   end

   // New mask only between frames
   always_ff @(posedge clk) begin
      if (reset) begin
         keep_mask <= '0;
      end else if (!comb_strobe) begin
         keep_mask <= chan_mask;
      end
   end

   chan_subset subset (
      .clk      (clk),
      .reset    (reset),
      .data_in  (comb_result),
      .gate_in  (comb_strobe),
      .keep     (keep_mask),
      .data_out (sub_data),
      .gate_out (sub_gate),
      .time_err (subset_err)
   );

   iq_phase_track cordic (
      .clk         (clk),
      .reset       (reset),
      .sample      (sub_data),
      .sample_gate (sub_gate),
      .phase       (phase),
      .magnitude   (magnitude),
      .pair_strobe (pair_strobe),
      .overrun_err (overrun_err)
   );

   freq_accum accum (
      .clk         (clk),
      .reset       (reset),
      .phase       (phase),
      .magnitude   (magnitude),
      .pair_strobe (pair_strobe),
      .overrun     (overrun_err),
      .freq        (reg_freq),
      .freq_valid  (reg_freq_valid),
      .amp_max     (reg_amp_max),
      .amp_min     (reg_amp_min),
      .updated     (reg_updated),
      .window_err  (window_err)
   );

   // Any timing fault along the chain
   assign reg_timing_err = subset_err | overrun_err | window_err;

endmodule

//--- tb/freq_monitor_assertions.sv
/*
   Frequency monitor checker, bound to the top level
   Checks quiet start, reported frequency and amplitudes,
   timing error handling and idle behavior
*/
module freq_monitor_assertions (
   input logic                                 clk,
   input logic                                 reset,
   input logic                                 sample_wave,
   input logic                                 sr_valid,
   input logic signed [freq_pkg::refcnt_w-1:0] reg_freq,
   input logic                                 reg_freq_valid,
   input logic [freq_pkg::mag_w-1:0]           reg_amp_max,
   input logic [freq_pkg::mag_w-1:0]           reg_amp_min,
   input logic                                 reg_updated,
   input logic                                 reg_timing_err,
   input int                                   exp_step,
   input int                                   exp_amp_hi,
   input int                                   exp_amp_lo,
   input logic                                 settled,
   input logic                                 fast_mode
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;
   logic seen_update;
   logic err_pending;
   logic valid_q;
   logic [7:0] frames_seen;

   always_ff @(posedge clk) begin
      if (reset) begin
         seen_update <= 1'b0;
         err_pending <= 1'b0;
         valid_q     <= 1'b0;
         frames_seen <= '0;
      end else begin
         valid_q <= sr_valid & sample_wave;
         // Frame starts, saturating
         if (sr_valid && sample_wave && !valid_q && frames_seen != 8'hff) begin
            frames_seen <= frames_seen + 1'b1;
         end
         if (reg_updated) begin
            seen_update <= 1'b1;
            err_pending <= 1'b0;
         end else if (reg_timing_err) begin
            err_pending <= 1'b1;
         end
      end
   end

   // Nothing reported before the first window closes
   a_quiet: assert property (@(posedge clk) disable iff (reset)
      !seen_update && !reg_updated |-> !reg_freq_valid && !reg_timing_err)
      else begin
         fail_count++;
         $error("reg_freq_valid or reg_timing_err high before the first window");
      end

   // Reference pair plus 64 steps
   a_first: assert property (@(posedge clk) disable iff (reset)
      reg_updated && !seen_update |-> frames_seen >= 8'd65)
      else begin
         fail_count++;
         $error("first reg_updated after only %0d frames", frames_seen);
      end

   a_freq: assert property (@(posedge clk) disable iff (reset)
      reg_updated && reg_freq_valid && settled |->
         (int'(reg_freq) - exp_step <= 8) && (exp_step - int'(reg_freq) <= 8))
      else begin
         fail_count++;
         $error("MISMATCH t=%0t reg_freq got %0d expected %0d", $time, reg_freq, exp_step);
      end

   // One percent of the expected magnitude
   a_amp_max: assert property (@(posedge clk) disable iff (reset)
      reg_updated && reg_freq_valid && settled |->
         (int'(reg_amp_max) - exp_amp_hi <= exp_amp_hi / 100) &&
         (exp_amp_hi - int'(reg_amp_max) <= exp_amp_hi / 100))
      else begin
         fail_count++;
         $error("MISMATCH t=%0t reg_amp_max got %0d expected %0d",
                $time, reg_amp_max, exp_amp_hi);
      end

   a_amp_min: assert property (@(posedge clk) disable iff (reset)
      reg_updated && reg_freq_valid && settled |->
         (int'(reg_amp_min) - exp_amp_lo <= exp_amp_lo / 100) &&
         (exp_amp_lo - int'(reg_amp_min) <= exp_amp_lo / 100))
      else begin
         fail_count++;
         $error("MISMATCH t=%0t reg_amp_min got %0d expected %0d",
                $time, reg_amp_min, exp_amp_lo);
      end

   a_err_window: assert property (@(posedge clk) disable iff (reset)
      reg_updated && err_pending |-> !reg_freq_valid)
      else begin
         fail_count++;
         $error("reg_freq_valid high for a window with a timing error");
      end

   // Back-to-back frames must be flagged
   a_fast_err: assert property (@(posedge clk) disable iff (reset)
      $rose(fast_mode) |-> ##[1:80] reg_timing_err)
      else begin
         fail_count++;
         $error("no reg_timing_err after frames were sent back to back");
      end

   a_idle: assert property (@(posedge clk) disable iff (reset)
      (!sample_wave) [*40] |-> !reg_updated)
      else begin
         fail_count++;
         $error("reg_updated pulsed with sample_wave low");
      end

endmodule

//--- tb/freq_monitor_tb.sv
/*
   Frequency monitor testbench
   Integrated tones on the belt, channel switches, overrun and idle runs
*/
module freq_monitor_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_tests = 7;
   localparam int cycle_limit = n_tests * 3 * 64 * 40;
   localparam real cordic_gain = 1.64676;
   localparam real two_pi = 6.283185307179586;
   localparam real full_turn = 131072.0;
   localparam int field_low_amp = 6000;

   logic clk;
   logic reset;
   logic [1:0] channel_sel;
   logic sample_wave;
   logic [3:0] wave_shift;
   logic sr_valid;
   logic [freq_pkg::sr_wi-1:0] sr_data;
   logic signed [freq_pkg::refcnt_w-1:0] reg_freq;
   logic reg_freq_valid;
   logic [freq_pkg::mag_w-1:0] reg_amp_max;
   logic [freq_pkg::mag_w-1:0] reg_amp_min;
   logic reg_updated;
   logic reg_timing_err;

   // Field, forward, reverse, fiber, drive, spare
   // Step in phase LSB per frame, amplitude in belt LSB
   int step_tab [6] = '{1200, 3000, -2500, 700, 5000, 0};
   int amp_tab [6] = '{12000, 10000, 8000, 11000, 9000, 0};
   real ph [6];
   logic [freq_pkg::sr_wi-1:0] integ [freq_pkg::n_chan];

   int exp_step;
   int exp_amp_hi;
   int exp_amp_lo;
   logic settled;
   logic fast_mode;
   int upd_count = 0;
   int upd_mark;
   int cycles = 0;
   int frame_no;
   int test_no;
   int change_pos;
   logic [1:0] change_sel;

   freq_monitor_top uut (
      .clk            (clk),
      .reset          (reset),
      .channel_sel    (channel_sel),
      .sample_wave    (sample_wave),
      .wave_shift     (wave_shift),
      .sr_valid       (sr_valid),
      .sr_data        (sr_data),
      .reg_freq       (reg_freq),
      .reg_freq_valid (reg_freq_valid),
      .reg_amp_max    (reg_amp_max),
      .reg_amp_min    (reg_amp_min),
      .reg_updated    (reg_updated),
      .reg_timing_err (reg_timing_err)
   );

   bind freq_monitor_top freq_monitor_assertions chk (
      .clk            (clk),
      .reset          (reset),
      .sample_wave    (sample_wave),
      .sr_valid       (sr_valid),
      .reg_freq       (reg_freq),
      .reg_freq_valid (reg_freq_valid),
      .reg_amp_max    (reg_amp_max),
      .reg_amp_min    (reg_amp_min),
      .reg_updated    (reg_updated),
      .reg_timing_err (reg_timing_err),
      .exp_step       (freq_monitor_tb.exp_step),
      .exp_amp_hi     (freq_monitor_tb.exp_amp_hi),
      .exp_amp_lo     (freq_monitor_tb.exp_amp_lo),
      .settled        (freq_monitor_tb.settled),
      .fast_mode      (freq_monitor_tb.fast_mode)
   );

   // Comb shift of 16, then the two LSBs are dropped before the CORDIC
   function automatic int mag_of(input int amp);
      return int'(cordic_gain * 4.0 * real'(amp));
   endfunction

   assign exp_step   = step_tab[channel_sel];
   assign exp_amp_hi = mag_of(amp_tab[channel_sel]);
   assign exp_amp_lo = (channel_sel == freq_pkg::field_chid) ? mag_of(field_low_amp)
                                                             : exp_amp_hi;
   // Window open at a channel switch is skipped
   assign settled = (upd_count > upd_mark);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (reg_updated) begin
         upd_count <= upd_count + 1;
      end
      if (cycles >= cycle_limit) begin
         $display("timeout: run still busy after %0d cycles", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Next tone samples, integrated, then twelve words and an idle gap
   task automatic send_frame(input int gap);
      int s_i;
      int s_q;
      int amp;
      for (int s = 0; s < 6; s++) begin
         amp = amp_tab[s];
         // Field alternates between its two amplitudes
         if (s == 0 && (frame_no % 2) == 1) begin
            amp = field_low_amp;
         end
         s_i = int'(real'(amp) * $cos(two_pi * ph[s] / full_turn));
         s_q = int'(real'(amp) * $sin(two_pi * ph[s] / full_turn));
         integ[2*s]   = integ[2*s] + 40'(s_i);
         integ[2*s+1] = integ[2*s+1] + 40'(s_q);
         ph[s] = ph[s] + real'(step_tab[s]);
      end
      frame_no++;
      for (int k = 0; k < freq_pkg::n_chan; k++) begin
         if (k == change_pos) begin
            channel_sel = change_sel;
            upd_mark    = upd_count;
            change_pos  = -1;
         end
         sr_valid = 1'b1;
         sr_data  = integ[k];
         @(posedge clk);
         #1;
      end
      sr_valid = 1'b0;
      repeat (gap) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_windows(input int n, input bit fast);
      int target;
      target = upd_count + n;
      while (upd_count < target) begin
         send_frame(fast ? 0 : 12 + int'($urandom % 4));
      end
   endtask

   // Switch lands in the middle of the next frame
   task automatic switch_channel(input logic [1:0] sel);
      change_sel = sel;
      change_pos = 5;
   endtask

   task automatic finish_test(input string name);
      test_no++;
      $display("test %0d %s: done at %0t, assertion failures so far %0d",
               test_no, name, $time, uut.chk.fail_count);
   endtask

   initial begin
      void'($urandom(32'h7ab0_04a5));
      clk         = 1'b0;
      reset       = 1'b1;
      channel_sel = freq_pkg::field_chid;
      sample_wave = 1'b1;
      wave_shift  = 4'd0;
      sr_valid    = 1'b0;
      sr_data     = '0;
      fast_mode   = 1'b0;
      change_pos  = -1;
      change_sel  = 2'd0;
      frame_no    = 0;
      test_no     = 0;
      upd_mark    = -1;
      for (int s = 0; s < 6; s++) begin
         ph[s] = real'($urandom % 131072);
      end
      for (int k = 0; k < freq_pkg::n_chan; k++) begin
         integ[k] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      run_windows(1, 1'b0);
      finish_test("first window after reset");
      run_windows(2, 1'b0);
      finish_test("field frequency and amplitude");
      switch_channel(freq_pkg::fwd_chid);
      run_windows(3, 1'b0);
      finish_test("forward after mid-frame switch");
      switch_channel(freq_pkg::rev_chid);
      run_windows(3, 1'b0);
      finish_test("reverse with negative step");
      switch_channel(freq_pkg::iqfib_chid);
      run_windows(3, 1'b0);
      finish_test("fiber after mid-frame switch");
      fast_mode = 1'b1;
      run_windows(2, 1'b1);
      fast_mode = 1'b0;
      run_windows(2, 1'b0);
      finish_test("overrun from back-to-back frames");
      sample_wave = 1'b0;
      repeat (128) send_frame(12);
      finish_test("sampling disabled");

      $display("tests %0d, assertion failures %0d", test_no, uut.chk.fail_count);
      if (uut.chk.fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
rtl/freq_pkg.sv
rtl/cic_comb_shift.sv
rtl/chan_subset.sv
rtl/iq_phase_track.sv
rtl/freq_accum.sv
rtl/freq_monitor_top.sv
tb/freq_monitor_assertions.sv
tb/freq_monitor_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = freq_monitor_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
